// File: rtl/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// reorder buffer depth, must stay a power of two so the pointers wrap
`define ROB_SIZE 8

// physical register tags come from the rename stage
`define NUM_REGS 64

// data and pc word width
`define XLEN 32

`endif

// File: rtl/rv32i_types_pkg.sv
`include "rob_consts.svh"

package rv32i_types;

    typedef logic [`XLEN-1:0]              word_t;      // data or pc
    typedef logic [4:0]                    arch_reg_t;
    typedef logic [$clog2(`NUM_REGS)-1:0]  phys_reg_t;
    typedef logic [$clog2(`ROB_SIZE)-1:0]  rob_idx_t;

    // renamed instruction from the front end
    typedef struct packed {
        word_t     pc;
        word_t     instr;
        arch_reg_t arch_rd;
        phys_reg_t phys_rd;
    } dispatch_pkt_t;

    // completion report from one execution port
    typedef struct packed {
        rob_idx_t  idx;
        word_t     rd_data;
        word_t     next_pc;
        logic      branch_mismatch;     // only meaningful on the alu port
    } complete_pkt_t;

    typedef struct packed {
        logic      valid;
        logic      done;
        logic      branch_mismatch;
        word_t     pc;
        word_t     instr;
        arch_reg_t arch_rd;
        phys_reg_t phys_rd;
    } rob_entry_t;

    // one retiring instruction
    typedef struct packed {
        word_t     pc;
        word_t     instr;
        arch_reg_t arch_rd;
        phys_reg_t phys_rd;
        word_t     rd_data;
        word_t     next_pc;
    } commit_pkt_t;

endpackage

// File: rtl/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       disp_req,
    input  rv32i_types::dispatch_pkt_t disp_pkt,
    input  logic                       full,
    input  logic                       flush,
    input  rv32i_types::rob_idx_t      alloc_idx,
    output logic                       disp_ack,
    output rv32i_types::rob_idx_t      disp_idx,
    output logic                       insert,
    output rv32i_types::dispatch_pkt_t insert_pkt
);

    typedef enum logic {
        WAIT_REQ,
        WAIT_RELEASE
    } disp_state_t;

    disp_state_t state;

    // accept only in the idle phase, and never into a full or flushing buffer
    assign insert     = (state == WAIT_REQ) && disp_req && !full && !flush;
    assign insert_pkt = disp_pkt;   // front end keeps the packet stable while req is high

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= WAIT_REQ;
            disp_ack <= 1'b0;
        end
        else
        begin
            case (state)
                WAIT_REQ:
                begin
                    if (insert)
                    begin
                        disp_ack <= 1'b1;
                        state    <= WAIT_RELEASE;
                    end
                end
                WAIT_RELEASE:
                begin
                    // second half of the four-phase handshake
                    if (!disp_req)
                    begin
                        disp_ack <= 1'b0;
                        state    <= WAIT_REQ;
                    end
                end
                default: state <= WAIT_REQ;
            endcase
        end
    end

    // slot index handed back with the ack
    always_ff @(posedge clk)
    begin
        if (insert)
        begin
            disp_idx <= alloc_idx;
        end
    end

endmodule

// File: rtl/rob.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob
#(
    parameter int ROB_SIZE = `ROB_SIZE
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       insert,
    input  rv32i_types::dispatch_pkt_t insert_pkt,
    input  logic                       alu_done,
    input  logic                       mul_done,
    input  logic                       ldst_done,
    input  rv32i_types::complete_pkt_t alu_cpl,
    input  rv32i_types::complete_pkt_t mul_cpl,
    input  rv32i_types::complete_pkt_t ldst_cpl,
    output rv32i_types::rob_idx_t      alloc_idx,
    output logic                       full,
    output logic                       empty,
    output logic                       commit_valid,
    output rv32i_types::commit_pkt_t   rob_line,
    output logic                       flush,
    output rv32i_types::word_t         missed_pc
);

    rv32i_types::rob_entry_t   entries  [ROB_SIZE];
    rv32i_types::word_t        res_data [ROB_SIZE];   // rd result per slot
    rv32i_types::word_t        res_npc  [ROB_SIZE];   // resolved next pc per slot
    rv32i_types::rob_idx_t     issue_ptr;
    rv32i_types::rob_idx_t     commit_ptr;
    rv32i_types::rob_entry_t   head;
    logic                      head_ret;
    logic [2:0]                cpl_done;
    rv32i_types::complete_pkt_t cpl [3];

    // port 0 is the alu; it is applied last so it wins a slot collision
    assign cpl_done[0] = alu_done;
    assign cpl_done[1] = mul_done;
    assign cpl_done[2] = ldst_done;
    assign cpl[0]      = alu_cpl;
    assign cpl[1]      = mul_cpl;
    assign cpl[2]      = ldst_cpl;

    assign head     = entries[commit_ptr];
    assign head_ret = head.valid && head.done;

    assign alloc_idx = issue_ptr;
    assign empty     = (issue_ptr == commit_ptr);
    assign full      = (rv32i_types::rob_idx_t'(issue_ptr + 1'b1) == commit_ptr); // one slot kept free

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < ROB_SIZE; i++)
            begin
                entries[i] <= '0;
            end
            issue_ptr    <= '0;
            commit_ptr   <= '0;
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end
        else
        begin
            commit_valid <= head_ret;
            flush        <= head_ret && head.branch_mismatch;

            if (insert && !full)
            begin
                entries[issue_ptr] <= '{valid:           1'b1,
                                        done:            1'b0,
                                        branch_mismatch: 1'b0,
                                        pc:              insert_pkt.pc,
                                        instr:           insert_pkt.instr,
                                        arch_rd:         insert_pkt.arch_rd,
                                        phys_rd:         insert_pkt.phys_rd};
                issue_ptr <= issue_ptr + 1'b1;
            end

            for (int i = 2; i >= 0; i--)
            begin
                if (cpl_done[i] && entries[cpl[i].idx].valid) // stray pulses are dropped
                begin
                    entries[cpl[i].idx].done            <= 1'b1;
                    entries[cpl[i].idx].branch_mismatch <= (i == 0) && cpl[i].branch_mismatch;
                end
            end

            if (head_ret)
            begin
                if (head.branch_mismatch)
                begin
                    // wrong path behind the head, throw everything away
                    for (int i = 0; i < ROB_SIZE; i++)
                    begin
                        entries[i] <= '0;
                    end
                    issue_ptr  <= '0;
                    commit_ptr <= '0;
                end
                else
                begin
                    entries[commit_ptr].valid <= 1'b0;
                    entries[commit_ptr].done  <= 1'b0;
                    commit_ptr <= commit_ptr + 1'b1;
                end
            end
        end
    end

    // result storage and the retirement line
    always_ff @(posedge clk)
    begin
        for (int i = 2; i >= 0; i--)
        begin
            if (cpl_done[i] && entries[cpl[i].idx].valid)
            begin
                res_data[cpl[i].idx] <= cpl[i].rd_data;
                res_npc[cpl[i].idx]  <= cpl[i].next_pc;
            end
        end

        if (head_ret)
        begin
            rob_line <= '{pc:      head.pc,
                          instr:   head.instr,
                          arch_rd: head.arch_rd,
                          phys_rd: head.phys_rd,
                          rd_data: res_data[commit_ptr],
                          next_pc: res_npc[commit_ptr]};
            if (head.branch_mismatch)
            begin
                missed_pc <= res_npc[commit_ptr]; // correct target from the alu
            end
        end
    end

endmodule

// File: rtl/commit_unit.sv
`timescale 1ns/1ps

module commit_unit
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     commit_valid,
    input  rv32i_types::commit_pkt_t rob_line,
    input  logic                     flush,
    input  rv32i_types::word_t       missed_pc,
    input  rv32i_types::arch_reg_t   rd_addr,
    output logic                     ret_valid,
    output rv32i_types::commit_pkt_t ret_pkt,
    output logic                     redirect,
    output rv32i_types::word_t       redirect_pc,
    output rv32i_types::word_t       rd_data
);

    rv32i_types::word_t arch_regs [32];

    // architectural register file, x0 is never written
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
            begin
                arch_regs[i] <= '0;
            end
        end
        else if (commit_valid && (rob_line.arch_rd != '0))
        begin
            arch_regs[rob_line.arch_rd] <= rob_line.rd_data;
        end
    end

    assign rd_data = arch_regs[rd_addr];    // debug / state read port

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ret_valid <= 1'b0;
            redirect  <= 1'b0;
        end
        else
        begin
            ret_valid <= commit_valid;
            redirect  <= flush;     // lands with the mispredicted entry's retirement
        end
    end

    always_ff @(posedge clk)
    begin
        if (commit_valid)
        begin
            ret_pkt <= rob_line;
        end
        if (flush)
        begin
            redirect_pc <= missed_pc;
        end
    end

endmodule

// File: rtl/rob_backend_top.sv
`timescale 1ns/1ps

module rob_backend_top
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       disp_req,
    input  rv32i_types::dispatch_pkt_t disp_pkt,
    input  logic                       alu_done,
    input  rv32i_types::complete_pkt_t alu_cpl,
    input  logic                       mul_done,
    input  rv32i_types::complete_pkt_t mul_cpl,
    input  logic                       ldst_done,
    input  rv32i_types::complete_pkt_t ldst_cpl,
    input  rv32i_types::arch_reg_t     rd_addr,
    output logic                       disp_ack,
    output rv32i_types::rob_idx_t      disp_idx,
    output logic                       ret_valid,
    output rv32i_types::commit_pkt_t   ret_pkt,
    output logic                       redirect,
    output rv32i_types::word_t         redirect_pc,
    output rv32i_types::word_t         rd_data
);

    logic                       insert;
    rv32i_types::dispatch_pkt_t insert_pkt;
    rv32i_types::rob_idx_t      alloc_idx;
    logic                       full;
    logic                       flush;
    logic                       commit_valid;
    rv32i_types::commit_pkt_t   rob_line;
    rv32i_types::word_t         missed_pc;

    dispatch_ctrl u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .disp_req   (disp_req),
        .disp_pkt   (disp_pkt),
        .full       (full),
        .flush      (flush),
        .alloc_idx  (alloc_idx),
        .disp_ack   (disp_ack),
        .disp_idx   (disp_idx),
        .insert     (insert),
        .insert_pkt (insert_pkt)
    );

    rob u_rob (
        .clk          (clk),
        .rst          (rst),
        .insert       (insert),
        .insert_pkt   (insert_pkt),
        .alu_done     (alu_done),
        .mul_done     (mul_done),
        .ldst_done    (ldst_done),
        .alu_cpl      (alu_cpl),
        .mul_cpl      (mul_cpl),
        .ldst_cpl     (ldst_cpl),
        .alloc_idx    (alloc_idx),
        .full         (full),
        .empty        (),
        .commit_valid (commit_valid),
        .rob_line     (rob_line),
        .flush        (flush),
        .missed_pc    (missed_pc)
    );

    commit_unit u_commit (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .rob_line     (rob_line),
        .flush        (flush),
        .missed_pc    (missed_pc),
        .rd_addr      (rd_addr),
        .ret_valid    (ret_valid),
        .ret_pkt      (ret_pkt),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .rd_data      (rd_data)
    );

endmodule

// File: dv/rob_backend_chk.sv
`timescale 1ns/1ps

module rob_backend_chk
(
    input logic clk,
    input logic rst,
    input logic disp_req,
    input logic disp_ack,
    input logic commit_valid,
    input logic ret_valid,
    input logic redirect
);

    // ack only answers a request
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(disp_ack) |-> $past(disp_req))
        else $error("disp_ack rose without a request");

    // front end keeps req up until the ack arrives
    req_held: assert property (@(posedge clk) disable iff (rst)
        disp_req && !disp_ack |=> disp_req || disp_ack)
        else $error("disp_req dropped before disp_ack");

    // wrong path never retires behind a redirect
    quiet_after_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !ret_valid)
        else $error("retirement in the cycle after a redirect");

    no_commit_in_reset: assert property (@(posedge clk)
        rst |=> !commit_valid)
        else $error("commit_valid high during reset");

endmodule

// File: dv/rob_backend_tb.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_backend_tb;

    localparam int MAX_ORD = 64;   // dispatches per run

    // one line of the pattern file
    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
    } pattern_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       disp_req;
    rv32i_types::dispatch_pkt_t disp_pkt;
    logic                       alu_done;
    logic                       mul_done;
    logic                       ldst_done;
    rv32i_types::complete_pkt_t alu_cpl;
    rv32i_types::complete_pkt_t mul_cpl;
    rv32i_types::complete_pkt_t ldst_cpl;
    rv32i_types::arch_reg_t     rd_addr;
    logic                       disp_ack;
    rv32i_types::rob_idx_t      disp_idx;
    logic                       ret_valid;
    rv32i_types::commit_pkt_t   ret_pkt;
    logic                       redirect;
    rv32i_types::word_t         redirect_pc;
    rv32i_types::word_t         rd_data;

    pattern_t                   pats [$];
    int                         seed = 32'h6f5024be;
    int                         n_errors = 0;
    int                         n_checks = 0;
    int                         cycles = 0;
    int                         limit = 100000;   // replaced once the patterns are loaded

    // reference model indexed by dispatch ordinal
    rv32i_types::dispatch_pkt_t ord_pkt  [MAX_ORD];
    rv32i_types::rob_idx_t      ord_slot [MAX_ORD];
    rv32i_types::word_t         ord_data [MAX_ORD];
    rv32i_types::word_t         ord_npc  [MAX_ORD];
    logic                       ord_done [MAX_ORD];
    logic                       ord_mism [MAX_ORD];
    int                         pend [$];        // in flight in program order
    rv32i_types::rob_idx_t      next_slot = '0;
    rv32i_types::word_t         model_regs [32];
    int                         n_disp = 0;
    logic                       hold_pending = 1'b0;
    int                         hold_ord = 0;

    rob_backend_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .disp_req    (disp_req),
        .disp_pkt    (disp_pkt),
        .alu_done    (alu_done),
        .alu_cpl     (alu_cpl),
        .mul_done    (mul_done),
        .mul_cpl     (mul_cpl),
        .ldst_done   (ldst_done),
        .ldst_cpl    (ldst_cpl),
        .rd_addr     (rd_addr),
        .disp_ack    (disp_ack),
        .disp_idx    (disp_idx),
        .ret_valid   (ret_valid),
        .ret_pkt     (ret_pkt),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rd_data     (rd_data)
    );

    bind rob_backend_top rob_backend_chk u_chk (
        .clk          (clk),
        .rst          (rst),
        .disp_req     (disp_req),
        .disp_ack     (disp_ack),
        .commit_valid (commit_valid),
        .ret_valid    (ret_valid),
        .redirect     (redirect)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        n_checks++;
        if (expected !== actual)
        begin
            n_errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report(input string what);
        n_errors++;
        $display("%s", what);
    endtask

    task automatic step();
        @(posedge clk);
        #1;     // drive point
    endtask

    task automatic load_patterns(output bit ok);
        int               fd;
        int               code;
        bit               more;
        logic [7:0]       kind;
        logic [31:0]      f_a;
        logic [31:0]      f_b;
        logic [31:0]      f_c;
        logic [31:0]      f_d;
        logic [31:0]      f_e;
        logic [8*128-1:0] rest;
        ok = 1'b0;
        fd = $fopen("dv/rob_patterns.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            more = 1'b1;
            while (more)
            begin
                f_a = '0;
                f_b = '0;
                f_c = '0;
                f_d = '0;
                f_e = '0;
                code = $fscanf(fd, " %c", kind);
                if (code != 1)
                    more = 1'b0;
                else if (kind == "#")
                    code = $fgets(rest, fd);    // comment line
                else
                begin
                    if (kind == "D")
                        code = $fscanf(fd, "%h %h %d %d", f_a, f_b, f_c, f_d);
                    else if (kind == "C")
                        code = $fscanf(fd, "%d %d %h %h %d", f_a, f_b, f_c, f_d, f_e);
                    pats.push_back('{kind: kind, a: f_a, b: f_b, c: f_c, d: f_d, e: f_e});
                end
            end
            $fclose(fd);
        end
    endtask

    // req is already high at the drive point
    task automatic finish_handshake(input int ord);
        step();
        while (disp_ack !== 1'b1)
            step();
        disp_req = 1'b0;
        check("disp_idx", 64'(ord_slot[ord]), 64'(disp_idx));
        step();
        while (disp_ack !== 1'b0)
            step();
    endtask

    task automatic dispatch_instr(input pattern_t p);
        int   ord;
        logic full_now;
        ord = n_disp;
        full_now = (pend.size() == `ROB_SIZE - 1);
        ord_pkt[ord] = '{pc:      p.a,
                         instr:   p.b,
                         arch_rd: rv32i_types::arch_reg_t'(p.c),
                         phys_rd: rv32i_types::phys_reg_t'(p.d)};
        ord_slot[ord] = next_slot;
        ord_done[ord] = 1'b0;
        ord_mism[ord] = 1'b0;
        next_slot = next_slot + 1'b1;
        n_disp++;
        pend.push_back(ord);
        disp_pkt = ord_pkt[ord];
        disp_req = 1'b1;
        if (full_now)
        begin
            // the request must wait for a retirement while the buffer is full
            repeat (6)
            begin
                step();
                check("full_hold_ack", 64'(1'b0), 64'(disp_ack));
            end
            hold_pending = 1'b1;
            hold_ord = ord;
        end
        else
            finish_handshake(ord);
    endtask

    task automatic pulse_completion(input pattern_t p);
        int                         ord;
        rv32i_types::complete_pkt_t c;
        ord = int'(p.b);
        c.idx = ord_slot[ord];
        c.rd_data = p.c;
        c.next_pc = p.d;
        c.branch_mismatch = p.e[0];
        ord_data[ord] = p.c;
        ord_npc[ord] = p.d;
        ord_mism[ord] = (p.a == 32'd0) && p.e[0];  // only the alu can mispredict
        ord_done[ord] = 1'b1;
        case (p.a)
            32'd0:
            begin
                alu_cpl = c;
                alu_done = 1'b1;
            end
            32'd1:
            begin
                mul_cpl = c;
                mul_done = 1'b1;
            end
            32'd2:
            begin
                ldst_cpl = c;
                ldst_done = 1'b1;
            end
            default: report("pattern file names an unknown completion port");
        endcase
        step();
        alu_done = 1'b0;
        mul_done = 1'b0;
        ldst_done = 1'b0;
        if (hold_pending)
        begin
            hold_pending = 1'b0;
            finish_handshake(hold_ord);
        end
    endtask

    task automatic drain();
        while (pend.size() != 0)
            step();
        repeat (4)
            step();     // room for a stray retirement to show up
    endtask

    task automatic read_back();
        for (int r = 0; r < 32; r++)
        begin
            step();
            rd_addr = rv32i_types::arch_reg_t'(r);
            @(negedge clk);
            check($sformatf("arch_reg_x%0d", r), 64'(model_regs[r]), 64'(rd_data));
        end
        step();
    endtask

    task automatic check_retirement();
        int ord;
        if (pend.size() == 0)
            report("an instruction retired while none was outstanding");
        else
        begin
            ord = pend.pop_front();
            if (!ord_done[ord])
                report($sformatf("instruction %0d retired before it completed", ord));
            check("ret_pc", 64'(ord_pkt[ord].pc), 64'(ret_pkt.pc));
            check("ret_instr", 64'(ord_pkt[ord].instr), 64'(ret_pkt.instr));
            check("ret_arch_rd", 64'(ord_pkt[ord].arch_rd), 64'(ret_pkt.arch_rd));
            check("ret_phys_rd", 64'(ord_pkt[ord].phys_rd), 64'(ret_pkt.phys_rd));
            check("ret_rd_data", 64'(ord_data[ord]), 64'(ret_pkt.rd_data));
            check("ret_next_pc", 64'(ord_npc[ord]), 64'(ret_pkt.next_pc));
            check("redirect", 64'(ord_mism[ord]), 64'(redirect));
            if (ord_pkt[ord].arch_rd != '0)
                model_regs[ord_pkt[ord].arch_rd] = ord_data[ord];
            if (ord_mism[ord])
            begin
                check("redirect_pc", 64'(ord_npc[ord]), 64'(redirect_pc));
                pend.delete();          // younger entries are gone
                next_slot = '0;
            end
        end
    endtask

    // retirement monitor samples at the falling edge where the outputs are stable
    always @(negedge clk)
    begin
        if (rst === 1'b0)
        begin
            if (ret_valid === 1'b1)
                check_retirement();
            else if (redirect === 1'b1)
                report("redirect raised without a retirement");
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout after %0d cycles, the run did not finish", limit);
            $display("summary: %0d checks, %0d errors", n_checks, n_errors);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        bit ok;
        int idle;
        rst = 1'b1;
        disp_req = 1'b0;
        disp_pkt = '0;
        alu_done = 1'b0;
        mul_done = 1'b0;
        ldst_done = 1'b0;
        alu_cpl = '0;
        mul_cpl = '0;
        ldst_cpl = '0;
        rd_addr = '0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        load_patterns(ok);
        if (!ok)
        begin
            $display("could not open the pattern file dv/rob_patterns.txt");
            $display("Errors found");
            $finish;
        end
        else
        begin
            limit = pats.size() * 20 + 10;
            repeat (10)
                @(posedge clk);
            #1;
            rst = 1'b0;
            foreach (pats[i])
            begin
                case (pats[i].kind)
                    "D": dispatch_instr(pats[i]);
                    "C": pulse_completion(pats[i]);
                    "W": drain();
                    "R": read_back();
                    default: report("pattern file holds an unknown operation");
                endcase
                idle = $unsigned($random(seed)) % 4;
                repeat (idle)
                    step();
            end
            $display("summary: %0d checks, %0d errors", n_checks, n_errors);
            if (n_errors == 0)
                $display("No errors");
            else
                $display("Errors found");
            $finish;
        end
    end

endmodule

// File: dv/rob_patterns.txt
# D pc instr arch_rd phys_rd | C port(0 alu, 1 mul, 2 ldst) ordinal data next_pc mismatch
# W waits until all dispatched work has retired or flushed | R reads back every register
D 00001000 00500093 1 11
D 00001004 00a00113 2 12
D 00001008 002081b3 3 13
C 2 2 0000000f 0000100c 0
C 1 1 0000000a 00001008 0
C 0 0 00000005 00001004 0
W
# fill the buffer, the eighth request has to wait
D 00002000 00000013 4 20
D 00002004 00000013 5 21
D 00002008 00000013 0 22
D 0000200c 00000013 6 23
D 00002010 00000013 7 24
D 00002014 00000013 8 25
D 00002018 00000013 9 26
D 0000201c 00000013 10 27
C 0 3 00000033 00002004 0
C 1 4 00000044 00002008 1
C 0 5 deadbeef 0000200c 0
C 2 6 00000066 00002010 1
C 0 7 00000077 00002014 0
C 1 8 00000088 00002018 0
C 2 9 00000099 0000201c 0
C 0 10 000000aa 00002020 0
W
# mispredict with a completed younger entry behind it
D 00003000 00c0006f 11 30
D 00003004 00100093 1 31
D 00003008 00200113 2 32
C 1 12 00000bad 00003008 0
C 0 11 00003004 00003100 1
W
D 00003100 00300193 3 33
C 2 14 00000333 00003104 0
W
R

// File: filelist.f
+incdir+rtl
rtl/rv32i_types_pkg.sv
rtl/dispatch_ctrl.sv
rtl/rob.sv
rtl/commit_unit.sv
rtl/rob_backend_top.sv
dv/rob_backend_chk.sv
dv/rob_backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_backend_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
